/* design/afu_pkg.sv */
/* All widths, CSR indices and encodings for the atomic accelerator.
   The engine count is fixed at one and the design runs on a single clock. */
`default_nettype none

package afu_pkg;

    // ============================================================
    // Widths
    // ============================================================

    // CSR and memory data width
    localparam int DATA_W = 64;
    // Memory word address
    localparam int ADDR_W = 32;
    // Index within one CSR group
    localparam int CSR_IDX_W = 4;
    localparam int NUM_CSRS = 1 << CSR_IDX_W;
    // Top bit picks the group, 0 global and 1 engine
    localparam int MMIO_ADDR_W = CSR_IDX_W + 1;

    localparam int NUM_ENGINES = 1;

    // Identifier returned by global CSRs 0 and 1
    localparam logic [127:0] TEST_ID = 128'h3f0a9c52_e1b7_4d86_a24c_70d95b13e8c6;

    // ============================================================
    // Engine CSR map
    // ============================================================

    // Write: start in bit 0, opcode in bits 2:1
    // Read: active in bit 0, done in bit 1
    localparam logic [CSR_IDX_W-1:0] CSR_CTRL      = 4'd0;
    localparam logic [CSR_IDX_W-1:0] CSR_BASE      = 4'd1;
    localparam logic [CSR_IDX_W-1:0] CSR_OPERAND   = 4'd2;
    localparam logic [CSR_IDX_W-1:0] CSR_COMPARE   = 4'd3;
    localparam logic [CSR_IDX_W-1:0] CSR_COUNT     = 4'd4;
    localparam logic [CSR_IDX_W-1:0] CSR_LAST      = 4'd5;
    localparam logic [CSR_IDX_W-1:0] CSR_COMPLETED = 4'd6;

    // Atomic memory operations
    typedef enum logic [1:0] {
        OP_ADD,
        OP_SWAP,
        OP_CAS
    } atomic_op_e;

    // Engine sequencer
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT,
        ST_DONE
    } eng_state_e;

endpackage

`default_nettype wire

/* design/engine_csr_if.sv */
/* CSR path between the CSR manager and one engine.
   Writes are single-cycle strobes and reads are a flat combinational array. */
`default_nettype none

interface engine_csr_if;

    // Write strobe from the manager, already decoded to the engine group
    logic                               wr_en;
    logic [afu_pkg::CSR_IDX_W-1:0]      wr_idx;
    logic [afu_pkg::DATA_W-1:0]         wr_data;

    // Current value of every engine CSR
    logic [afu_pkg::DATA_W-1:0]         rd_data [afu_pkg::NUM_CSRS];

    // Engine busy with a run
    logic                               active;

    // Manager side
    modport mgr (
        output wr_en,
        output wr_idx,
        output wr_data,
        input  rd_data,
        input  active
    );

    // Engine side
    modport eng (
        input  wr_en,
        input  wr_idx,
        input  wr_data,
        output rd_data,
        output active
    );

endinterface

`default_nettype wire

/* design/csr_mgr.sv */
/* Read data arrives exactly one cycle after mmio_rd; global CSRs are read only.
   mmio_wr and mmio_rd must never be high in the same cycle. */
`default_nettype none

module csr_mgr (
    input  wire                                 clk,
    input  wire                                 rst_n,

    // Host MMIO
    input  wire                                 mmio_wr,
    input  wire                                 mmio_rd,
    input  wire  [afu_pkg::MMIO_ADDR_W-1:0]     mmio_addr,
    input  wire  [afu_pkg::DATA_W-1:0]          mmio_wdata,
    output logic                                mmio_rvalid,
    output logic [afu_pkg::DATA_W-1:0]          mmio_rdata,

    // Engine CSR group
    engine_csr_if.mgr                           eng_csr
);

    // ============================================================
    // Address split
    // ============================================================

    logic                               grp_eng;
    logic [afu_pkg::CSR_IDX_W-1:0]      csr_idx;

    // Group select in the top address bit
    assign grp_eng = mmio_addr[afu_pkg::MMIO_ADDR_W-1];
    assign csr_idx = mmio_addr[afu_pkg::CSR_IDX_W-1:0];

    // ============================================================
    // Global CSRs
    // ============================================================

    logic [afu_pkg::DATA_W-1:0]         glob_rd [afu_pkg::NUM_CSRS];

    always_comb
    begin
        // Unused global slots read as zero
        for (int i = 0; i < afu_pkg::NUM_CSRS; i++)
        begin
            glob_rd[i] = '0;
        end

        // Test identifier, low word first
        glob_rd[0] = afu_pkg::TEST_ID[63:0];
        glob_rd[1] = afu_pkg::TEST_ID[127:64];

        // Engine count in the low byte
        glob_rd[2] = {56'd0, 8'(afu_pkg::NUM_ENGINES)};
    end

    // ============================================================
    // Engine writes
    // ============================================================

    // Passed straight through, the engine registers them
    assign eng_csr.wr_en   = mmio_wr && grp_eng;
    assign eng_csr.wr_idx  = csr_idx;
    assign eng_csr.wr_data = mmio_wdata;

    // Global-group writes fall on the floor

    // ============================================================
    // Read response
    // ============================================================

    logic [afu_pkg::DATA_W-1:0]         rd_mux;

    // Pick the group for the addressed index
    always_comb
    begin
        if (grp_eng)
        begin
            rd_mux = eng_csr.rd_data[csr_idx];
        end
        else
        begin
            rd_mux = glob_rd[csr_idx];
        end
    end

    // Valid strobe, one cycle behind the request
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mmio_rvalid <= 1'b0;
        end
        else
        begin
            mmio_rvalid <= mmio_rd;
        end
    end

    // Data capture only on a read
    always_ff @(posedge clk)
    begin
        if (mmio_rd)
        begin
            mmio_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* design/atomic_engine.sv */
/* One request in flight; memory must accept every mem_req pulse.
   Configuration writes and starts are ignored while a run is active. */
`default_nettype none

module atomic_engine (
    input  wire                                 clk,
    input  wire                                 rst_n,

    // CSR access from the manager
    engine_csr_if.eng                           csrs,

    // Host memory requests
    output logic                                mem_req,
    output afu_pkg::atomic_op_e                 mem_op,
    output logic [afu_pkg::ADDR_W-1:0]          mem_addr,
    output logic [afu_pkg::DATA_W-1:0]          mem_operand,
    output logic [afu_pkg::DATA_W-1:0]          mem_compare,

    // Old word returned by memory
    input  wire                                 mem_rsp_valid,
    input  wire  [afu_pkg::DATA_W-1:0]          mem_rsp_data
);

    afu_pkg::eng_state_e                state;
    afu_pkg::atomic_op_e                op_q;

    logic [afu_pkg::ADDR_W-1:0]         base_q;
    logic [afu_pkg::ADDR_W-1:0]         count_q;
    logic [afu_pkg::ADDR_W-1:0]         completed_q;
    logic [afu_pkg::DATA_W-1:0]         operand_q;
    logic [afu_pkg::DATA_W-1:0]         compare_q;
    logic [afu_pkg::DATA_W-1:0]         last_q;

    logic                               active;
    logic                               done;
    logic                               cfg_wr;
    logic                               start;
    logic                               rsp_final;

    // ============================================================
    // Decode
    // ============================================================

    assign active = (state == afu_pkg::ST_ISSUE) || (state == afu_pkg::ST_WAIT);
    assign done   = (state == afu_pkg::ST_DONE);

    // Any CSR write taken outside a run
    assign cfg_wr = csrs.wr_en && !active;

    // Start bit on a control write
    assign start = cfg_wr && (csrs.wr_idx == afu_pkg::CSR_CTRL) && csrs.wr_data[0];

    // Response that finishes the programmed count
    assign rsp_final = mem_rsp_valid
                       && ((completed_q + afu_pkg::ADDR_W'(1)) == count_q);

    // ============================================================
    // Operand registers
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (cfg_wr)
        begin
            case (csrs.wr_idx)
                afu_pkg::CSR_BASE:    base_q    <= csrs.wr_data[afu_pkg::ADDR_W-1:0];
                afu_pkg::CSR_OPERAND: operand_q <= csrs.wr_data;
                afu_pkg::CSR_COMPARE: compare_q <= csrs.wr_data;
                default: ;
            endcase
        end

        // Old value of the most recent operation
        if ((state == afu_pkg::ST_WAIT) && mem_rsp_valid)
        begin
            last_q <= mem_rsp_data;
        end
    end

    // ============================================================
    // Sequencer
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state       <= afu_pkg::ST_IDLE;
            op_q        <= afu_pkg::OP_ADD;
            count_q     <= '0;
            completed_q <= '0;
        end
        else
        begin
            if (cfg_wr && (csrs.wr_idx == afu_pkg::CSR_COUNT))
            begin
                count_q <= csrs.wr_data[afu_pkg::ADDR_W-1:0];
            end

            case (state)
                afu_pkg::ST_ISSUE:
                begin
                    // Request goes out this cycle
                    state <= afu_pkg::ST_WAIT;
                end
                afu_pkg::ST_WAIT:
                begin
                    if (mem_rsp_valid)
                    begin
                        completed_q <= completed_q + afu_pkg::ADDR_W'(1);
                        state       <= rsp_final ? afu_pkg::ST_DONE : afu_pkg::ST_ISSUE;
                    end
                end
                default:
                begin
                    // Idle or done, waiting for a start
                    if (start)
                    begin
                        op_q        <= afu_pkg::atomic_op_e'(csrs.wr_data[2:1]);
                        completed_q <= '0;
                        // Zero count finishes at once
                        if (count_q == '0)
                        begin
                            state <= afu_pkg::ST_DONE;
                        end
                        else
                        begin
                            state <= afu_pkg::ST_ISSUE;
                        end
                    end
                end
            endcase
        end
    end

    // ============================================================
    // Memory request
    // ============================================================

    assign mem_req     = (state == afu_pkg::ST_ISSUE);
    assign mem_op      = op_q;
    // Request i targets base plus i
    assign mem_addr    = base_q + completed_q;
    assign mem_operand = operand_q;
    assign mem_compare = compare_q;

    // ============================================================
    // CSR read values
    // ============================================================

    always_comb
    begin
        // Unimplemented indices read as zero
        for (int i = 0; i < afu_pkg::NUM_CSRS; i++)
        begin
            csrs.rd_data[i] = '0;
        end

        csrs.rd_data[afu_pkg::CSR_CTRL]      = {62'd0, done, active};
        csrs.rd_data[afu_pkg::CSR_BASE]      = 64'(base_q);
        csrs.rd_data[afu_pkg::CSR_OPERAND]   = operand_q;
        csrs.rd_data[afu_pkg::CSR_COMPARE]   = compare_q;
        csrs.rd_data[afu_pkg::CSR_COUNT]     = 64'(count_q);
        csrs.rd_data[afu_pkg::CSR_LAST]      = last_q;
        csrs.rd_data[afu_pkg::CSR_COMPLETED] = 64'(completed_q);
    end

    assign csrs.active = active;

endmodule

`default_nettype wire

/* design/afu_top.sv */
/* Single clock, synchronous active-low reset.
   Memory latency must be at least one cycle with no back-pressure. */
`default_nettype none

module afu_top (
    input  wire                                 clk,
    input  wire                                 rst_n,

    // Host MMIO
    input  wire                                 mmio_wr,
    input  wire                                 mmio_rd,
    input  wire  [afu_pkg::MMIO_ADDR_W-1:0]     mmio_addr,
    input  wire  [afu_pkg::DATA_W-1:0]          mmio_wdata,
    output logic                                mmio_rvalid,
    output logic [afu_pkg::DATA_W-1:0]          mmio_rdata,

    // Host memory
    output logic                                mem_req,
    output afu_pkg::atomic_op_e                 mem_op,
    output logic [afu_pkg::ADDR_W-1:0]          mem_addr,
    output logic [afu_pkg::DATA_W-1:0]          mem_operand,
    output logic [afu_pkg::DATA_W-1:0]          mem_compare,
    input  wire                                 mem_rsp_valid,
    input  wire  [afu_pkg::DATA_W-1:0]          mem_rsp_data
);

    // Engine CSR group
    engine_csr_if u_eng_csr ();

    // ============================================================
    // CSR decode
    // ============================================================

    csr_mgr u_csr_mgr (
        .clk         (clk),
        .rst_n       (rst_n),
        .mmio_wr     (mmio_wr),
        .mmio_rd     (mmio_rd),
        .mmio_addr   (mmio_addr),
        .mmio_wdata  (mmio_wdata),
        .mmio_rvalid (mmio_rvalid),
        .mmio_rdata  (mmio_rdata),
        .eng_csr     (u_eng_csr.mgr)
    );

    // ============================================================
    // Atomic engine
    // ============================================================

    atomic_engine u_engine (
        .clk           (clk),
        .rst_n         (rst_n),
        .csrs          (u_eng_csr.eng),
        .mem_req       (mem_req),
        .mem_op        (mem_op),
        .mem_addr      (mem_addr),
        .mem_operand   (mem_operand),
        .mem_compare   (mem_compare),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

endmodule

`default_nettype wire

/* tb/afu_checker.sv */
/* Protocol rules for afu_top, bound in below; fail_count is read by the testbench.
   Taps the engine active flag through the CSR interface instance. */
`default_nettype none

module afu_checker (
    input wire clk,
    input wire rst_n,
    input wire mmio_rd,
    input wire mmio_rvalid,
    input wire mem_req,
    input wire mem_rsp_valid,
    input wire active
);

    timeunit 1ns;
    timeprecision 100ps;

    int   fail_count = 0;
    logic outstanding;

    // Request sent, response not yet back
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            outstanding <= 1'b0;
        else if (mem_req)
            outstanding <= 1'b1;
        else if (mem_rsp_valid)
            outstanding <= 1'b0;
    end

    // ============================================================
    // Rules
    // ============================================================

    // Read strobe answered exactly one cycle later
    rvalid_follows_rd : assert property (@(posedge clk) disable iff (!rst_n)
        mmio_rvalid == $past(mmio_rd))
    else
    begin
        fail_count++;
        $error("mmio_rvalid does not follow mmio_rd by one cycle");
    end

    // Requests are single-cycle pulses
    req_is_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |=> !mem_req)
    else
    begin
        fail_count++;
        $error("mem_req high on two consecutive cycles");
    end

    // One request in flight
    one_in_flight : assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> !outstanding)
    else
    begin
        fail_count++;
        $error("second mem_req before mem_rsp_valid");
    end

    // No traffic outside a run
    req_only_active : assert property (@(posedge clk) disable iff (!rst_n)
        !active |-> !mem_req)
    else
    begin
        fail_count++;
        $error("mem_req while the engine is not active");
    end

endmodule

bind afu_top afu_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .mmio_rd       (mmio_rd),
    .mmio_rvalid   (mmio_rvalid),
    .mem_req       (mem_req),
    .mem_rsp_valid (mem_rsp_valid),
    .active        (u_eng_csr.active)
);

`default_nettype wire

/* tb/afu_top_tb.sv */
/* Memory model holds 64 words, so table bases and counts stay inside that window.
   Response latency is 1 to 4 cycles, drawn from a seeded LFSR. */
`default_nettype none

module afu_top_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NUM_ROWS     = 7;
    localparam int          RESET_CYCLES = 8;
    localparam int          CYCLE_LIMIT  = 200 * NUM_ROWS + RESET_CYCLES;
    localparam logic [31:0] LFSR_SEED    = 32'h1d465e9b;

    // One table row per engine run
    typedef struct {
        afu_pkg::atomic_op_e        op;
        logic [afu_pkg::ADDR_W-1:0] base;
        logic [afu_pkg::DATA_W-1:0] operand;
        logic [afu_pkg::DATA_W-1:0] compare;
        int                         count;
        logic [7:0]                 preset;
        logic                       restart;
    } row_t;

    logic                                clk;
    logic                                rst_n;
    logic                                mmio_wr;
    logic                                mmio_rd;
    logic [afu_pkg::MMIO_ADDR_W-1:0]     mmio_addr;
    logic [afu_pkg::DATA_W-1:0]          mmio_wdata;
    logic                                mmio_rvalid;
    logic [afu_pkg::DATA_W-1:0]          mmio_rdata;
    logic                                mem_req;
    afu_pkg::atomic_op_e                 mem_op;
    logic [afu_pkg::ADDR_W-1:0]          mem_addr;
    logic [afu_pkg::DATA_W-1:0]          mem_operand;
    logic [afu_pkg::DATA_W-1:0]          mem_compare;
    logic                                mem_rsp_valid;
    logic [afu_pkg::DATA_W-1:0]          mem_rsp_data;

    row_t                                table_rows [NUM_ROWS];
    logic [afu_pkg::DATA_W-1:0]          mem [64];
    logic [afu_pkg::DATA_W-1:0]          shadow [64];
    logic [afu_pkg::DATA_W-1:0]          exp_last;
    logic [31:0]                         lfsr_state;

    // Expected request stream of the current run
    afu_pkg::atomic_op_e                 cur_op;
    logic [afu_pkg::ADDR_W-1:0]          cur_base;
    logic [afu_pkg::DATA_W-1:0]          cur_operand;
    logic [afu_pkg::DATA_W-1:0]          cur_compare;
    int                                  req_count;

    int                                  errors = 0;
    int                                  checks = 0;
    int                                  cycles = 0;

    afu_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .mmio_wr       (mmio_wr),
        .mmio_rd       (mmio_rd),
        .mmio_addr     (mmio_addr),
        .mmio_wdata    (mmio_wdata),
        .mmio_rvalid   (mmio_rvalid),
        .mmio_rdata    (mmio_rdata),
        .mem_req       (mem_req),
        .mem_op        (mem_op),
        .mem_addr      (mem_addr),
        .mem_operand   (mem_operand),
        .mem_compare   (mem_compare),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ============================================================
    // Helpers
    // ============================================================

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // Memory update rules
    function automatic logic [afu_pkg::DATA_W-1:0] apply_atomic(
        input afu_pkg::atomic_op_e op, input logic [afu_pkg::DATA_W-1:0] old,
        input logic [afu_pkg::DATA_W-1:0] operand, input logic [afu_pkg::DATA_W-1:0] compare);
        case (op)
            afu_pkg::OP_ADD:  return old + operand;
            afu_pkg::OP_SWAP: return operand;
            afu_pkg::OP_CAS:  return (old == compare) ? operand : old;
            default:          return old;
        endcase
    endfunction

    function automatic logic [afu_pkg::MMIO_ADDR_W-1:0] csr_addr(
        input logic grp, input logic [afu_pkg::CSR_IDX_W-1:0] idx);
        return {grp, idx};
    endfunction

    task automatic check_word(input string what, input logic [afu_pkg::DATA_W-1:0] got,
                              input logic [afu_pkg::DATA_W-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_op(input string what, input afu_pkg::atomic_op_e got,
                            input afu_pkg::atomic_op_e exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s got %s expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    // Called 1 ns after a rising edge and returns at the same point
    task automatic mmio_write(input logic [afu_pkg::MMIO_ADDR_W-1:0] addr,
                              input logic [afu_pkg::DATA_W-1:0] data);
        mmio_wr    = 1'b1;
        mmio_addr  = addr;
        mmio_wdata = data;
        @(posedge clk);
        #1;
        mmio_wr = 1'b0;
    endtask

    task automatic mmio_read(input logic [afu_pkg::MMIO_ADDR_W-1:0] addr,
                             output logic [afu_pkg::DATA_W-1:0] data);
        mmio_rd   = 1'b1;
        mmio_addr = addr;
        @(posedge clk);
        #1;
        mmio_rd = 1'b0;
        if (mmio_rvalid !== 1'b1)
        begin
            errors++;
            $display("Read of CSR address %h came back without mmio_rvalid", addr);
        end
        data = mmio_rdata;
    endtask

    task automatic load_table();
        table_rows[0] = '{afu_pkg::OP_ADD, 32'd2, 64'h0000_0001_0000_0003, 64'h0, 6, 8'h00, 1'b0};
        table_rows[1] = '{afu_pkg::OP_SWAP, 32'd12, 64'hdead_beef_0bad_f00d, 64'h0, 5, 8'h00,
                          1'b0};
        table_rows[2] = '{afu_pkg::OP_CAS, 32'd20, 64'h1111_2222_3333_4444,
                          64'h5a5a_a5a5_0f0f_f0f0, 8, 8'ha6, 1'b0};
        // Overlaps row 0, second start and count write land mid-run
        table_rows[3] = '{afu_pkg::OP_ADD, 32'd4, 64'hffff_ffff_ffff_ffff, 64'h0, 4, 8'h00, 1'b1};
        table_rows[4] = '{afu_pkg::OP_ADD, 32'd40, 64'h1, 64'h0, 0, 8'h00, 1'b0};
        table_rows[5] = '{afu_pkg::OP_CAS, 32'd60, 64'h0123_4567_89ab_cdef,
                          64'hcafe_f00d_1234_5678, 4, 8'h05, 1'b0};
        table_rows[6] = '{afu_pkg::OP_SWAP, 32'd33, 64'h7777_0000_7777_0000, 64'h0, 1, 8'h00,
                          1'b1};
    endtask

    // Program, start, wait for done, then compare with the shadow memory
    task automatic run_row(input row_t row);
        logic [afu_pkg::DATA_W-1:0] rd;
        logic [afu_pkg::DATA_W-1:0] old;
        logic [5:0]                 idx;

        // CAS targets preset to the compare value
        for (int i = 0; i < 8; i++)
        begin
            if (i < row.count && row.preset[i])
            begin
                idx         = 6'(row.base + i);
                mem[idx]    = row.compare;
                shadow[idx] = row.compare;
            end
        end

        cur_op      = row.op;
        cur_base    = row.base;
        cur_operand = row.operand;
        cur_compare = row.compare;
        req_count   = 0;

        mmio_write(csr_addr(1'b1, afu_pkg::CSR_BASE), 64'(row.base));
        mmio_write(csr_addr(1'b1, afu_pkg::CSR_OPERAND), row.operand);
        mmio_write(csr_addr(1'b1, afu_pkg::CSR_COMPARE), row.compare);
        mmio_write(csr_addr(1'b1, afu_pkg::CSR_COUNT), 64'(row.count));
        mmio_write(csr_addr(1'b1, afu_pkg::CSR_CTRL), {61'd0, row.op, 1'b1});

        // Both writes must be dropped while active
        if (row.restart)
        begin
            mmio_write(csr_addr(1'b1, afu_pkg::CSR_CTRL), 64'h5);
            mmio_write(csr_addr(1'b1, afu_pkg::CSR_COUNT), 64'd9);
        end

        // Poll status, watchdog covers a run that never ends
        do
        begin
            mmio_read(csr_addr(1'b1, afu_pkg::CSR_CTRL), rd);
        end
        while (rd[1] !== 1'b1);
        check_word("status at done", rd, 64'h2);

        for (int i = 0; i < row.count; i++)
        begin
            idx         = 6'(row.base + i);
            old         = shadow[idx];
            shadow[idx] = apply_atomic(row.op, old, row.operand, row.compare);
            exp_last    = old;
        end

        mmio_read(csr_addr(1'b1, afu_pkg::CSR_LAST), rd);
        check_word("last old value", rd, exp_last);
        mmio_read(csr_addr(1'b1, afu_pkg::CSR_COMPLETED), rd);
        check_word("completed count", rd, 64'(row.count));
        check_word("requests issued", 64'(req_count), 64'(row.count));

        // Whole window, also catches stray writes
        for (int w = 0; w < 64; w++)
        begin
            check_word($sformatf("memory word %0d", w), mem[w], shadow[w]);
        end
    endtask

    // ============================================================
    // Memory model
    // ============================================================

    initial
    begin : memory_model
        int                         rsp_wait;
        logic [afu_pkg::DATA_W-1:0] rsp_old;
        logic [5:0]                 idx;

        rsp_wait      = 0;
        rsp_old       = '0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        forever
        begin
            @(posedge clk);
            #1;
            mem_rsp_valid = 1'b0;
            if (rsp_wait > 0)
            begin
                rsp_wait--;
                if (rsp_wait == 0)
                begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data  = rsp_old;
                end
            end
            else if (rst_n && mem_req === 1'b1)
            begin
                check_op("request opcode", mem_op, cur_op);
                check_word("request address", 64'(mem_addr), 64'(cur_base + req_count));
                check_word("request operand", mem_operand, cur_operand);
                check_word("request compare", mem_compare, cur_compare);
                idx      = mem_addr[5:0];
                rsp_old  = mem[idx];
                mem[idx] = apply_atomic(mem_op, rsp_old, mem_operand, mem_compare);
                req_count++;
                // 1 to 4 cycles
                rsp_wait = 1 + {lfsr_next_bit(), lfsr_next_bit()};
            end
        end
    end

    // ============================================================
    // Watchdog
    // ============================================================

    initial
    begin : watchdog
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

    // ============================================================
    // Stimulus
    // ============================================================

    initial
    begin : stimulus
        logic [afu_pkg::DATA_W-1:0] rd;
        logic [afu_pkg::DATA_W-1:0] exp;
        int                         errs_before;

        rst_n      = 1'b0;
        mmio_wr    = 1'b0;
        mmio_rd    = 1'b0;
        mmio_addr  = '0;
        mmio_wdata = '0;
        load_table();

        // Memory contents from the LFSR, shadow starts equal
        lfsr_state = LFSR_SEED;
        for (int w = 0; w < 64; w++)
        begin
            for (int b = 0; b < afu_pkg::DATA_W; b++)
            begin
                mem[w][b] = lfsr_next_bit();
            end
        end
        shadow = mem;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset state and global group
        errs_before = errors;
        mmio_read(csr_addr(1'b1, afu_pkg::CSR_CTRL), rd);
        check_word("status after reset", rd, '0);
        for (int g = 0; g < afu_pkg::NUM_CSRS; g++)
        begin
            case (g)
                0:       exp = afu_pkg::TEST_ID[63:0];
                1:       exp = afu_pkg::TEST_ID[127:64];
                2:       exp = 64'(afu_pkg::NUM_ENGINES);
                default: exp = '0;
            endcase
            mmio_read(csr_addr(1'b0, afu_pkg::CSR_IDX_W'(g)), rd);
            check_word($sformatf("global csr %0d", g), rd, exp);
        end
        $display("test reset and global csrs: %s", (errors == errs_before) ? "ok" : "mismatch");

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            errs_before = errors;
            run_row(table_rows[r]);
            $display("test %0d %s base %0d count %0d: %s", r, table_rows[r].op.name(),
                     table_rows[r].base, table_rows[r].count,
                     (errors == errs_before) ? "ok" : "mismatch");
        end

        if (u_dut.u_checker.fail_count != 0)
        begin
            $display("Protocol assertions fired %0d times", u_dut.u_checker.fail_count);
            errors += u_dut.u_checker.fail_count;
        end

        $display("%0d tests, %0d checks, %0d errors", NUM_ROWS + 1, checks, errors);
        if (errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* afu_top.f */
design/afu_pkg.sv
design/engine_csr_if.sv
design/csr_mgr.sv
design/atomic_engine.sv
design/afu_top.sv
tb/afu_checker.sv
tb/afu_top_tb.sv
